//--- include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// First fetch address out of reset
`define CPU_RESET_VECTOR 32'hBFC00000
`define CPU_WORD_WIDTH 32
`define CPU_REG_COUNT 32

// Primary opcodes
`define CPU_OP_SPECIAL 6'd0
`define CPU_OP_J 6'd2
`define CPU_OP_BEQ 6'd4
`define CPU_OP_BNE 6'd5
`define CPU_OP_ADDIU 6'd9
`define CPU_OP_SLTI 6'd10
`define CPU_OP_SLTIU 6'd11
`define CPU_OP_ANDI 6'd12
`define CPU_OP_ORI 6'd13
`define CPU_OP_XORI 6'd14
`define CPU_OP_LUI 6'd15
`define CPU_OP_LW 6'd35
`define CPU_OP_SW 6'd43

// Funct codes under SPECIAL
`define CPU_FN_SLL 6'd0
`define CPU_FN_SRL 6'd2
`define CPU_FN_SRA 6'd3
`define CPU_FN_JR 6'd8
`define CPU_FN_ADDU 6'd33
`define CPU_FN_SUBU 6'd35
`define CPU_FN_AND 6'd36
`define CPU_FN_OR 6'd37
`define CPU_FN_XOR 6'd38
`define CPU_FN_SLT 6'd42
`define CPU_FN_SLTU 6'd43

`endif

//--- logic/mipsPkg.sv
`include "cpu_defs.svh"

package mipsPkg;

    // Meaningful widths
    typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
    typedef logic [4:0] regIdx_t;
    typedef logic [4:0] shamt_t;
    typedef logic [15:0] imm_t;
    typedef logic [25:0] target_t;

    // Multicycle sequencer states
    typedef enum logic [2:0] {
        StFetch,
        StDecode,
        StExecute,
        StMemory,
        StWriteback,
        StHalt
    } cpuState_t;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluSltu,
        AluSll,
        AluSrl,
        AluSra,
        AluLui
    } aluOp_t;

    // Fields and flags of the instruction being executed
    typedef struct packed {
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t rd;
        shamt_t shamt;
        imm_t imm;
        target_t target;
        logic isRType;
        logic isLoad;
        logic isStore;
        logic isBeq;
        logic isBne;
        logic isJump;
        logic isJr;
        // ANDI/ORI/XORI take the immediate unsigned
        logic zeroExt;
        aluOp_t aluOp;
        // Zero when the instruction writes no register
        regIdx_t dest;
    } decodedInstr_t;

    // Bus request from the sequencer
    typedef struct packed {
        logic read;
        logic write;
        // Data address on the bus instead of the PC
        logic dataPhase;
    } busReq_t;

    // Bus is big-endian, the core works little-endian
    function automatic word_t byteSwap(input word_t w);
        byteSwap = {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

//--- logic/instrDecoder.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module instrDecoder (
    input logic clk,
    input logic reset,
    input logic capture,
    input mipsPkg::word_t busWord,
    output mipsPkg::decodedInstr_t instr
);

    mipsPkg::word_t instrWord;
    logic [5:0] opcode;
    logic [5:0] funct;

    // Held until the next fetch completes; reset value decodes as a NOP
    always_ff @(posedge clk) begin
        if (reset) begin
            instrWord <= '0;
        end else if (capture) begin
            instrWord <= mipsPkg::byteSwap(busWord);
        end
    end

    assign opcode = instrWord[31:26];
    assign funct = instrWord[5:0];

    always_comb begin
        instr = '0;
        instr.rs = instrWord[25:21];
        instr.rt = instrWord[20:16];
        instr.rd = instrWord[15:11];
        instr.shamt = instrWord[10:6];
        instr.imm = instrWord[15:0];
        instr.target = instrWord[25:0];
        instr.aluOp = mipsPkg::AluAdd;
        // I-type default target is rt
        instr.dest = instrWord[20:16];
        case (opcode)
            `CPU_OP_SPECIAL: begin
                instr.isRType = 1'b1;
                instr.dest = instrWord[15:11];
                case (funct)
                    `CPU_FN_ADDU: instr.aluOp = mipsPkg::AluAdd;
                    `CPU_FN_SUBU: instr.aluOp = mipsPkg::AluSub;
                    `CPU_FN_AND: instr.aluOp = mipsPkg::AluAnd;
                    `CPU_FN_OR: instr.aluOp = mipsPkg::AluOr;
                    `CPU_FN_XOR: instr.aluOp = mipsPkg::AluXor;
                    `CPU_FN_SLT: instr.aluOp = mipsPkg::AluSlt;
                    `CPU_FN_SLTU: instr.aluOp = mipsPkg::AluSltu;
                    `CPU_FN_SLL: instr.aluOp = mipsPkg::AluSll;
                    `CPU_FN_SRL: instr.aluOp = mipsPkg::AluSrl;
                    `CPU_FN_SRA: instr.aluOp = mipsPkg::AluSra;
                    `CPU_FN_JR: begin
                        instr.isJr = 1'b1;
                        instr.dest = '0;
                    end
                    // Unsupported funct runs as a NOP
                    default: instr.dest = '0;
                endcase
            end
            `CPU_OP_ADDIU: instr.aluOp = mipsPkg::AluAdd;
            `CPU_OP_SLTI: instr.aluOp = mipsPkg::AluSlt;
            `CPU_OP_SLTIU: instr.aluOp = mipsPkg::AluSltu;
            `CPU_OP_ANDI: begin
                instr.aluOp = mipsPkg::AluAnd;
                instr.zeroExt = 1'b1;
            end
            `CPU_OP_ORI: begin
                instr.aluOp = mipsPkg::AluOr;
                instr.zeroExt = 1'b1;
            end
            `CPU_OP_XORI: begin
                instr.aluOp = mipsPkg::AluXor;
                instr.zeroExt = 1'b1;
            end
            `CPU_OP_LUI: instr.aluOp = mipsPkg::AluLui;
            `CPU_OP_LW: instr.isLoad = 1'b1;
            `CPU_OP_SW: begin
                instr.isStore = 1'b1;
                instr.dest = '0;
            end
            `CPU_OP_BEQ: begin
                instr.isBeq = 1'b1;
                instr.dest = '0;
            end
            `CPU_OP_BNE: begin
                instr.isBne = 1'b1;
                instr.dest = '0;
            end
            `CPU_OP_J: begin
                instr.isJump = 1'b1;
                instr.dest = '0;
            end
            default: instr.dest = '0;
        endcase
    end

endmodule

//--- logic/regFile.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module regFile (
    input logic clk,
    input logic reset,
    input logic writeEn,
    input mipsPkg::regIdx_t writeIdx,
    input mipsPkg::regIdx_t rsIdx,
    input mipsPkg::regIdx_t rtIdx,
    input mipsPkg::word_t writeData,
    output mipsPkg::word_t rsValue,
    output mipsPkg::word_t rtValue,
    output mipsPkg::word_t v0
);

    mipsPkg::word_t regs [`CPU_REG_COUNT];

    // $zero is cleared by reset and never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeIdx != '0)) begin
            regs[writeIdx] <= writeData;
        end
    end

    // Asynchronous read ports
    assign rsValue = regs[rsIdx];
    assign rtValue = regs[rtIdx];

    // $v0 is register 2
    assign v0 = regs[2];

endmodule

//--- logic/alu.sv
`timescale 1ns/100ps

module alu (
    input mipsPkg::aluOp_t op,
    input mipsPkg::word_t a,
    input mipsPkg::word_t b,
    input mipsPkg::shamt_t shamt,
    output mipsPkg::word_t result
);

    logic signedLess;
    logic unsignedLess;

    // Compares for the set-less-than pair
    assign signedLess = $signed(a) < $signed(b);
    assign unsignedLess = a < b;

    always_comb begin
        case (op)
            // Both wrap, no overflow trap
            mipsPkg::AluAdd: result = a + b;
            mipsPkg::AluSub: result = a - b;
            mipsPkg::AluAnd: result = a & b;
            mipsPkg::AluOr: result = a | b;
            mipsPkg::AluXor: result = a ^ b;
            mipsPkg::AluSlt: begin
                result = '0;
                result[0] = signedLess;
            end
            mipsPkg::AluSltu: begin
                result = '0;
                result[0] = unsignedLess;
            end
            // Shifts act on b, the rt operand
            mipsPkg::AluSll: result = b << shamt;
            mipsPkg::AluSrl: result = b >> shamt;
            // Arithmetic shift keeps the sign bit
            mipsPkg::AluSra: result = mipsPkg::word_t'($signed(b) >>> shamt);
            // Immediate into the upper half
            mipsPkg::AluLui: result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

endmodule

//--- logic/cpuControl.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpuControl (
    input logic clk,
    input logic reset,
    input mipsPkg::decodedInstr_t instr,
    input mipsPkg::word_t rsValue,
    input mipsPkg::word_t rtValue,
    input mipsPkg::word_t aluResult,
    input mipsPkg::word_t loadData,
    input logic waitrequest,
    output logic capture,
    output mipsPkg::busReq_t busReq,
    output mipsPkg::word_t dataAddress,
    output mipsPkg::word_t storeData,
    output mipsPkg::word_t aluA,
    output mipsPkg::word_t aluB,
    output mipsPkg::aluOp_t aluOp,
    output mipsPkg::shamt_t shamt,
    output logic regWrite,
    output mipsPkg::regIdx_t regWriteIdx,
    output mipsPkg::word_t regWriteData,
    output mipsPkg::word_t pc,
    output logic active
);

    mipsPkg::cpuState_t state;
    mipsPkg::word_t immSext;
    mipsPkg::word_t pcPlus4;
    mipsPkg::word_t branchDest;
    mipsPkg::word_t nextPc;
    mipsPkg::word_t jumpTarget;
    mipsPkg::word_t resultReg;
    mipsPkg::word_t loadReg;
    logic delaySlot;
    logic isBranch;
    logic taken;
    logic finish;

    assign immSext = {{16{instr.imm[15]}}, instr.imm};
    assign pcPlus4 = pc + 32'd4;

    // Operand B is rt for R-type, else the extended immediate
    assign aluA = rsValue;
    assign aluB = instr.isRType ? rtValue :
                  (instr.zeroExt ? {16'h0000, instr.imm} : immSext);
    assign aluOp = instr.aluOp;
    assign shamt = instr.shamt;

    // Effective address rs + offset
    assign dataAddress = rsValue + immSext;
    assign storeData = rtValue;

    // Control transfers and their targets
    assign isBranch = instr.isBeq | instr.isBne | instr.isJump | instr.isJr;
    assign taken = instr.isJump | instr.isJr |
                   (instr.isBeq & (rsValue == rtValue)) |
                   (instr.isBne & (rsValue != rtValue));
    always_comb begin
        if (instr.isJr) begin
            branchDest = rsValue;
        end else if (instr.isJump) begin
            branchDest = {pcPlus4[31:28], instr.target, 2'b00};
        end else begin
            branchDest = pcPlus4 + {immSext[29:0], 2'b00};
        end
    end

    // Last cycle of the current instruction
    always_comb begin
        case (state)
            mipsPkg::StExecute: finish = isBranch;
            mipsPkg::StMemory: finish = !waitrequest && instr.isStore;
            mipsPkg::StWriteback: finish = 1'b1;
            default: finish = 1'b0;
        endcase
    end

    // Delay-slot instruction hands over to the pending target
    assign nextPc = delaySlot ? jumpTarget : pcPlus4;

    // Bus strobes held as levels through waitrequest
    assign busReq.read = (state == mipsPkg::StFetch) ||
                         ((state == mipsPkg::StMemory) && instr.isLoad);
    assign busReq.write = (state == mipsPkg::StMemory) && instr.isStore;
    assign busReq.dataPhase = (state == mipsPkg::StMemory);
    assign capture = (state == mipsPkg::StFetch) && !waitrequest;

    assign regWrite = (state == mipsPkg::StWriteback);
    assign regWriteIdx = instr.dest;
    assign regWriteData = instr.isLoad ? loadReg : resultReg;

    assign active = (state != mipsPkg::StHalt);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mipsPkg::StFetch;
            pc <= `CPU_RESET_VECTOR;
            delaySlot <= 1'b0;
            jumpTarget <= '0;
        end else begin
            case (state)
                mipsPkg::StFetch: begin
                    if (!waitrequest) begin
                        state <= mipsPkg::StDecode;
                    end
                end
                mipsPkg::StDecode: state <= mipsPkg::StExecute;
                mipsPkg::StExecute: begin
                    if (instr.isLoad || instr.isStore) begin
                        state <= mipsPkg::StMemory;
                    end else if (!isBranch) begin
                        state <= mipsPkg::StWriteback;
                    end
                end
                mipsPkg::StMemory: begin
                    // Store ends here, load goes on to writeback
                    if (!waitrequest && instr.isLoad) begin
                        state <= mipsPkg::StWriteback;
                    end
                end
                default: state <= state;
            endcase
            if (finish) begin
                pc <= nextPc;
                // A taken branch arms the target for after its delay slot
                delaySlot <= (state == mipsPkg::StExecute) && taken;
                if ((state == mipsPkg::StExecute) && taken) begin
                    jumpTarget <= branchDest;
                end
                // Fetch from address 0 means halt
                state <= (nextPc == '0) ? mipsPkg::StHalt : mipsPkg::StFetch;
            end
        end
    end

    // Result and load word kept for writeback
    always_ff @(posedge clk) begin
        if (state == mipsPkg::StExecute) begin
            resultReg <= aluResult;
        end
        if ((state == mipsPkg::StMemory) && !waitrequest) begin
            loadReg <= loadData;
        end
    end

endmodule

//--- logic/busMaster.sv
`timescale 1ns/100ps

module busMaster (
    input mipsPkg::busReq_t busReq,
    input mipsPkg::word_t pc,
    input mipsPkg::word_t dataAddress,
    input mipsPkg::word_t storeData,
    input mipsPkg::word_t readdata,
    output mipsPkg::word_t address,
    output mipsPkg::word_t writedata,
    output mipsPkg::word_t loadData,
    output logic read,
    output logic write,
    output logic [3:0] byteenable
);

    // PC during fetch, effective address during memory
    assign address = busReq.dataPhase ? dataAddress : pc;

    // Strobes follow the sequencer levels
    assign read = busReq.read;
    assign write = busReq.write;

    // Word accesses only
    assign byteenable = 4'b1111;

    // Byte 0 on the bus carries the MSB
    assign writedata = mipsPkg::byteSwap(storeData);
    assign loadData = mipsPkg::byteSwap(readdata);

endmodule

//--- logic/mipsCpuBus.sv
`timescale 1ns/100ps

module mipsCpuBus (
    input logic clk,
    input logic reset,
    output logic active,
    output mipsPkg::word_t register_v0,

    // Avalon-style master
    output mipsPkg::word_t address,
    output logic write,
    output logic read,
    input logic waitrequest,
    output mipsPkg::word_t writedata,
    output logic [3:0] byteenable,
    input mipsPkg::word_t readdata
);

    mipsPkg::decodedInstr_t instr;
    mipsPkg::busReq_t busReq;
    mipsPkg::word_t rsValue;
    mipsPkg::word_t rtValue;
    mipsPkg::word_t aluA;
    mipsPkg::word_t aluB;
    mipsPkg::word_t aluResult;
    mipsPkg::aluOp_t aluOp;
    mipsPkg::shamt_t shamt;
    mipsPkg::word_t loadData;
    mipsPkg::word_t dataAddress;
    mipsPkg::word_t storeData;
    mipsPkg::word_t pc;
    mipsPkg::regIdx_t regWriteIdx;
    mipsPkg::word_t regWriteData;
    logic regWrite;
    logic capture;

    // Instruction word straight off the bus
    instrDecoder decoder_i (
        .clk(clk), .reset(reset), .capture(capture), .busWord(readdata), .instr(instr)
    );

    cpuControl control_i (
        .clk(clk), .reset(reset), .instr(instr),
        .rsValue(rsValue), .rtValue(rtValue), .aluResult(aluResult), .loadData(loadData),
        .waitrequest(waitrequest), .capture(capture), .busReq(busReq),
        .dataAddress(dataAddress), .storeData(storeData),
        .aluA(aluA), .aluB(aluB), .aluOp(aluOp), .shamt(shamt),
        .regWrite(regWrite), .regWriteIdx(regWriteIdx), .regWriteData(regWriteData),
        .pc(pc), .active(active)
    );

    // Register indices come from the held instruction
    regFile regs_i (
        .clk(clk), .reset(reset), .writeEn(regWrite), .writeIdx(regWriteIdx),
        .rsIdx(instr.rs), .rtIdx(instr.rt), .writeData(regWriteData),
        .rsValue(rsValue), .rtValue(rtValue), .v0(register_v0)
    );

    alu alu_i (.op(aluOp), .a(aluA), .b(aluB), .shamt(shamt), .result(aluResult));

    busMaster bus_i (
        .busReq(busReq), .pc(pc), .dataAddress(dataAddress), .storeData(storeData),
        .readdata(readdata), .address(address), .writedata(writedata),
        .loadData(loadData), .read(read), .write(write), .byteenable(byteenable)
    );

endmodule

//--- tb/memoryModel.sv
`timescale 1ns/100ps

module memoryModel #(
    parameter int MAX_WAIT = 3
) (
    input logic clk,
    input logic randomWait,
    input logic clear,
    input logic loadEn,
    input mipsPkg::word_t loadAddr,
    input mipsPkg::word_t loadData,
    input mipsPkg::word_t address,
    input logic read,
    input logic write,
    input mipsPkg::word_t writedata,
    input logic [3:0] byteenable,
    output logic waitrequest,
    output mipsPkg::word_t readdata,
    output int storeCount,
    output mipsPkg::word_t lastStoreAddress,
    output mipsPkg::word_t lastStoreData,
    output logic [3:0] lastStoreByteEnable
);

    // Words kept in bus byte order, keyed by word address
    mipsPkg::word_t mem [logic [29:0]];
    integer seed = 32'h806ba4d1;
    int waitRun;

    // Unwritten words read back as a pattern of the full address
    function automatic mipsPkg::word_t readWord(input mipsPkg::word_t addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return addr ^ 32'h5EEDC0DE;
    endfunction

    initial begin
        waitrequest = 1'b0;
        readdata = '0;
        storeCount = 0;
        waitRun = 0;
        lastStoreAddress = '0;
        lastStoreData = '0;
        lastStoreByteEnable = '0;
    end

    // Bus inputs to the DUT change on the falling edge
    always @(negedge clk) begin
        logic [31:0] rnd;
        rnd = $random(seed);
        // At most MAX_WAIT wait cycles in a row
        if (randomWait && (waitRun < MAX_WAIT) && rnd[0]) begin
            waitrequest <= 1'b1;
            waitRun <= waitRun + 1;
        end else begin
            waitrequest <= 1'b0;
            waitRun <= 0;
        end
        // Read data valid for the whole cycle
        if (read) begin
            readdata <= readWord(address);
        end
    end

    // Program loading and bus stores
    always @(posedge clk) begin
        if (clear) begin
            mem.delete();
            storeCount <= 0;
        end else if (loadEn) begin
            mem[loadAddr[31:2]] = loadData;
        end else if (write && !waitrequest) begin
            mem[address[31:2]] = writedata;
            // Store trace, last transfer only
            storeCount <= storeCount + 1;
            lastStoreAddress <= address;
            lastStoreData <= writedata;
            lastStoreByteEnable <= byteenable;
        end
    end

endmodule

//--- tb/mipsCpuBusTb.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module mipsCpuBusTb;

    localparam int MAX_WAIT = 3;
    localparam int PROG_MAX = 12;
    localparam mipsPkg::regIdx_t RegZero = 5'd0;
    localparam mipsPkg::regIdx_t RegV0 = 5'd2;
    localparam mipsPkg::regIdx_t RegT0 = 5'd8;
    localparam mipsPkg::regIdx_t RegT1 = 5'd9;
    localparam mipsPkg::word_t SignBit = 32'h80000000;

    typedef enum logic [4:0] {
        OpAddu, OpSubu, OpAnd, OpOr, OpXor, OpSlt, OpSltu,
        OpSll, OpSrl, OpSra,
        OpAddiu, OpAndi, OpOri, OpXori, OpLui, OpSlti, OpSltiu,
        OpSwLw, OpBeq, OpBne
    } testOp_t;

    // One row of the test table
    typedef struct packed {
        testOp_t op;
        mipsPkg::word_t a;
        mipsPkg::word_t b;
        mipsPkg::word_t expected;
    } testEntry_t;

    logic clk;
    logic reset;
    logic active;
    mipsPkg::word_t v0;
    mipsPkg::word_t address;
    logic write;
    logic read;
    logic waitrequest;
    mipsPkg::word_t writedata;
    logic [3:0] byteenable;
    mipsPkg::word_t readdata;

    // Memory model controls
    logic randomWait;
    logic clearMem;
    logic loadEn;
    mipsPkg::word_t loadAddr;
    mipsPkg::word_t loadData;
    int storeCount;
    mipsPkg::word_t lastStoreAddress;
    mipsPkg::word_t lastStoreData;
    logic [3:0] lastStoreByteEnable;

    testEntry_t tests[$];
    string testNames[$];
    mipsPkg::word_t progWords[$];
    mipsPkg::word_t firstReadAddress;
    mipsPkg::word_t lastFetchAddress;
    logic sawFirstRead;
    int busWaitCount = 0;
    int checkCount = 0;
    int mismatchCount = 0;
    int otherErrors = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    mipsCpuBus mipsCpuBus_i (
        .clk(clk), .reset(reset), .active(active), .register_v0(v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    memoryModel #(.MAX_WAIT(MAX_WAIT)) memory_i (
        .clk(clk), .randomWait(randomWait), .clear(clearMem), .loadEn(loadEn),
        .loadAddr(loadAddr), .loadData(loadData), .address(address), .read(read),
        .write(write), .writedata(writedata), .byteenable(byteenable),
        .waitrequest(waitrequest), .readdata(readdata), .storeCount(storeCount),
        .lastStoreAddress(lastStoreAddress), .lastStoreData(lastStoreData),
        .lastStoreByteEnable(lastStoreByteEnable)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Bus byte 0 carries the most significant byte
    function automatic mipsPkg::word_t toBusOrder(input mipsPkg::word_t w);
        mipsPkg::word_t r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = w[8*(3-i) +: 8];
        end
        return r;
    endfunction

    function automatic mipsPkg::word_t iType(input logic [5:0] op, input mipsPkg::regIdx_t rs,
                                             input mipsPkg::regIdx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mipsPkg::word_t rType(input mipsPkg::regIdx_t rs,
                                             input mipsPkg::regIdx_t rt,
                                             input mipsPkg::regIdx_t rd,
                                             input logic [4:0] sh, input logic [5:0] funct);
        return {6'd0, rs, rt, rd, sh, funct};
    endfunction

    // Reference results from the instruction rules
    function automatic mipsPkg::word_t modelResult(input testOp_t op, input mipsPkg::word_t a,
                                                   input mipsPkg::word_t b);
        mipsPkg::word_t immS;
        mipsPkg::word_t immZ;
        logic [4:0] sh;
        logic equal;
        immS = {{16{b[15]}}, b[15:0]};
        immZ = {16'h0000, b[15:0]};
        sh = b[4:0];
        equal = (a == b);
        case (op)
            OpAddu: return a + b;
            OpSubu: return a - b;
            OpAnd: return a & b;
            OpOr: return a | b;
            OpXor: return a ^ b;
            // Flipping the sign bit turns a signed compare into unsigned
            OpSlt: return {31'd0, (a ^ SignBit) < (b ^ SignBit)};
            OpSltu: return {31'd0, a < b};
            OpSll: return a << sh;
            OpSrl: return a >> sh;
            OpSra: return (a >> sh) | (a[31] ? ~(32'hFFFFFFFF >> sh) : 32'h0);
            OpAddiu: return a + immS;
            OpAndi: return a & immZ;
            OpOri: return a | immZ;
            OpXori: return a ^ immZ;
            OpLui: return {b[15:0], 16'h0000};
            OpSlti: return {31'd0, (a ^ SignBit) < (immS ^ SignBit)};
            // Immediate sign-extended, then compared unsigned
            OpSltiu: return {31'd0, a < immS};
            OpSwLw: return a;
            // 1 + 2 from the delay slot + 8 from the target, 4 only if not taken
            OpBeq: return equal ? 32'd11 : 32'd15;
            OpBne: return equal ? 32'd15 : 32'd11;
            default: return '0;
        endcase
    endfunction

    task automatic addTest(input string name, input testOp_t op, input mipsPkg::word_t a,
                           input mipsPkg::word_t b);
        testEntry_t entry;
        entry.op = op;
        entry.a = a;
        entry.b = b;
        entry.expected = modelResult(op, a, b);
        tests.push_back(entry);
        testNames.push_back(name);
    endtask

    task automatic buildTable();
        addTest("addu wrap", OpAddu, 32'h7FFFFFFF, 32'h00000001);
        addTest("addu carry", OpAddu, 32'hFFFFFFFF, 32'h00000002);
        addTest("subu", OpSubu, 32'h00000005, 32'h00000007);
        addTest("and", OpAnd, 32'hF0F0A5A5, 32'hFF00FF00);
        addTest("or", OpOr, 32'hF0F00000, 32'h0000A5A5);
        addTest("xor", OpXor, 32'hFFFF0000, 32'h12345678);
        addTest("slt neg", OpSlt, 32'hFFFFFFFF, 32'h00000001);
        addTest("slt pos", OpSlt, 32'h00000001, 32'hFFFFFFFF);
        addTest("sltu big", OpSltu, 32'hFFFFFFFF, 32'h00000001);
        addTest("sltu small", OpSltu, 32'h00000001, 32'hFFFFFFFF);
        addTest("sll", OpSll, 32'h80000001, 32'h00000004);
        addTest("srl", OpSrl, 32'h80000010, 32'h00000004);
        addTest("sra", OpSra, 32'h80000010, 32'h00000004);
        addTest("addiu", OpAddiu, 32'h0000000A, 32'h0000FFF0);
        addTest("andi", OpAndi, 32'hFFFF1234, 32'h000080FF);
        addTest("ori", OpOri, 32'h12340000, 32'h00008001);
        addTest("xori", OpXori, 32'hFFFFFFFF, 32'h00008000);
        addTest("lui", OpLui, 32'h00000000, 32'h00008765);
        addTest("slti", OpSlti, 32'hFFFFFFFB, 32'h0000FFFE);
        addTest("sltiu", OpSltiu, 32'h00000005, 32'h0000FFFF);
        addTest("sw lw a", OpSwLw, 32'hCAFE1234, 32'h00001000);
        addTest("sw lw b", OpSwLw, 32'h01020304, 32'h00002008);
        addTest("beq taken", OpBeq, 32'h00000042, 32'h00000042);
        addTest("beq not taken", OpBeq, 32'h00000042, 32'h00000043);
        addTest("bne taken", OpBne, 32'h00000042, 32'h00000043);
        addTest("bne not taken", OpBne, 32'h00000042, 32'h00000042);
    endtask

    // Operands into $t0 and $t1, the operation, then JR $zero and a NOP
    task automatic buildProgram(input testEntry_t t);
        progWords.delete();
        progWords.push_back(iType(`CPU_OP_LUI, RegZero, RegT0, t.a[31:16]));
        progWords.push_back(iType(`CPU_OP_ORI, RegT0, RegT0, t.a[15:0]));
        progWords.push_back(iType(`CPU_OP_LUI, RegZero, RegT1, t.b[31:16]));
        progWords.push_back(iType(`CPU_OP_ORI, RegT1, RegT1, t.b[15:0]));
        case (t.op)
            OpAddu: progWords.push_back(rType(RegT0, RegT1, RegV0, 5'd0, `CPU_FN_ADDU));
            OpSubu: progWords.push_back(rType(RegT0, RegT1, RegV0, 5'd0, `CPU_FN_SUBU));
            OpAnd: progWords.push_back(rType(RegT0, RegT1, RegV0, 5'd0, `CPU_FN_AND));
            OpOr: progWords.push_back(rType(RegT0, RegT1, RegV0, 5'd0, `CPU_FN_OR));
            OpXor: progWords.push_back(rType(RegT0, RegT1, RegV0, 5'd0, `CPU_FN_XOR));
            OpSlt: progWords.push_back(rType(RegT0, RegT1, RegV0, 5'd0, `CPU_FN_SLT));
            OpSltu: progWords.push_back(rType(RegT0, RegT1, RegV0, 5'd0, `CPU_FN_SLTU));
            // Shift amount from B, value from $t0
            OpSll: progWords.push_back(rType(RegZero, RegT0, RegV0, t.b[4:0], `CPU_FN_SLL));
            OpSrl: progWords.push_back(rType(RegZero, RegT0, RegV0, t.b[4:0], `CPU_FN_SRL));
            OpSra: progWords.push_back(rType(RegZero, RegT0, RegV0, t.b[4:0], `CPU_FN_SRA));
            OpAddiu: progWords.push_back(iType(`CPU_OP_ADDIU, RegT0, RegV0, t.b[15:0]));
            OpAndi: progWords.push_back(iType(`CPU_OP_ANDI, RegT0, RegV0, t.b[15:0]));
            OpOri: progWords.push_back(iType(`CPU_OP_ORI, RegT0, RegV0, t.b[15:0]));
            OpXori: progWords.push_back(iType(`CPU_OP_XORI, RegT0, RegV0, t.b[15:0]));
            OpLui: progWords.push_back(iType(`CPU_OP_LUI, RegZero, RegV0, t.b[15:0]));
            OpSlti: progWords.push_back(iType(`CPU_OP_SLTI, RegT0, RegV0, t.b[15:0]));
            OpSltiu: progWords.push_back(iType(`CPU_OP_SLTIU, RegT0, RegV0, t.b[15:0]));
            OpSwLw: begin
                progWords.push_back(iType(`CPU_OP_SW, RegT1, RegT0, 16'h0000));
                progWords.push_back(iType(`CPU_OP_LW, RegT1, RegV0, 16'h0000));
            end
            default: begin
                progWords.push_back(iType(`CPU_OP_ADDIU, RegZero, RegV0, 16'd1));
                // Offset 2 skips one word after the delay slot
                progWords.push_back(iType((t.op == OpBeq) ? `CPU_OP_BEQ : `CPU_OP_BNE,
                                          RegT0, RegT1, 16'd2));
                progWords.push_back(iType(`CPU_OP_ADDIU, RegV0, RegV0, 16'd2));
                progWords.push_back(iType(`CPU_OP_ADDIU, RegV0, RegV0, 16'd4));
                progWords.push_back(iType(`CPU_OP_ADDIU, RegV0, RegV0, 16'd8));
            end
        endcase
        progWords.push_back(rType(RegZero, RegZero, RegZero, 5'd0, `CPU_FN_JR));
        progWords.push_back(32'h00000000);
    endtask

    task automatic checkWord(input string what, input mipsPkg::word_t expected,
                             input mipsPkg::word_t actual);
        checkCount++;
        assert (actual === expected) else begin
            mismatchCount++;
            $display("Mismatch %s: expected %08h, actual %08h", what, expected, actual);
        end
    endtask

    task automatic checkTrue(input bit cond, input string problem);
        checkCount++;
        assert (cond) else begin
            otherErrors++;
            $display("Error: %s", problem);
        end
    endtask

    task automatic printSummary();
        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 checkCount, mismatchCount, otherErrors);
    endtask

    // Bus observation where inputs and outputs are settled
    always @(posedge clk) begin
        if (reset) begin
            sawFirstRead <= 1'b0;
        end else begin
            if (read && !sawFirstRead) begin
                firstReadAddress <= address;
                sawFirstRead <= 1'b1;
            end
            if (read && !waitrequest && (address >= `CPU_RESET_VECTOR)) begin
                lastFetchAddress <= address;
            end
            // Transfers stretched by back-pressure
            if ((read || write) && waitrequest) begin
                busWaitCount <= busWaitCount + 1;
            end
        end
    end

    task automatic runTest(input int idx, input bit useRandom);
        testEntry_t t;
        string name;
        t = tests[idx];
        name = $sformatf("%s (%s)", testNames[idx], useRandom ? "random wait" : "no wait");
        buildProgram(t);
        @(negedge clk);
        randomWait = useRandom;
        clearMem = 1'b1;
        @(negedge clk);
        clearMem = 1'b0;
        foreach (progWords[k]) begin
            loadEn = 1'b1;
            loadAddr = `CPU_RESET_VECTOR + 32'(k * 4);
            loadData = toBusOrder(progWords[k]);
            @(negedge clk);
        end
        loadEn = 1'b0;
        // Reset for 8 cycles with the program in place
        reset = 1'b1;
        repeat (8) @(negedge clk);
        checkTrue(active === 1'b1, $sformatf("%s: active is not high after reset", name));
        reset = 1'b0;
        while (active !== 1'b0) begin
            @(negedge clk);
        end
        checkTrue(!read && !write, $sformatf("%s: bus strobe still high after halt", name));
        checkWord({name, " first fetch"}, `CPU_RESET_VECTOR, firstReadAddress);
        // Halt only after the delay slot of JR $zero
        checkWord({name, " last fetch"},
                  `CPU_RESET_VECTOR + 32'((progWords.size() - 1) * 4), lastFetchAddress);
        checkWord({name, " v0"}, t.expected, v0);
        if (t.op == OpSwLw) begin
            checkTrue(storeCount == 1, $sformatf("%s: expected one store, saw %0d", name,
                                                 storeCount));
            checkWord({name, " store address"}, t.b, lastStoreAddress);
            checkWord({name, " store data"}, toBusOrder(t.a), lastStoreData);
            checkWord({name, " byteenable"}, 32'hF, {28'd0, lastStoreByteEnable});
        end
    endtask

    initial begin
        reset = 1'b1;
        randomWait = 1'b0;
        clearMem = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        buildTable();
        // Two passes, each with load and reset cycles on top of the program
        cycleLimit = tests.size() * 2 * (PROG_MAX * 5 * (MAX_WAIT + 1) + PROG_MAX + 12) + 200;
        for (int i = 0; i < tests.size(); i++) begin
            runTest(i, 1'b0);
        end
        for (int i = 0; i < tests.size(); i++) begin
            runTest(i, 1'b1);
        end
        // Random pass only counts if the bus really stalled
        checkTrue(busWaitCount > 0, "waitrequest never stalled a bus transfer");
        printSummary();
        if ((mismatchCount == 0) && (otherErrors == 0)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if ((cycleLimit > 0) && (cycleCount >= cycleLimit)) begin
            otherErrors++;
            $display("Timeout: the CPU did not halt within %0d cycles", cycleLimit);
            printSummary();
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

//--- tb.f
+incdir+include
logic/mipsPkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/cpuControl.sv
logic/busMaster.sv
logic/mipsCpuBus.sv
tb/memoryModel.sv
tb/mipsCpuBusTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --assert
TOP ?= mipsCpuBusTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
